// File: hdl/axil_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite bus definitions
// widths, channel field types and the request/response
// structs that carry one master/slave link
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package axil_pkg;

    localparam int AXIL_ADDR_W = 32;
    localparam int AXIL_DATA_W = 32;

    typedef logic [AXIL_ADDR_W-1:0]   axil_addr_t;
    typedef logic [AXIL_DATA_W-1:0]   axil_data_t;
    typedef logic [AXIL_DATA_W/8-1:0] axil_strb_t;
    typedef logic [1:0]               axil_resp_t;

    localparam axil_resp_t AXIL_OKAY = 2'b00;

    // master to slave
    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        axil_strb_t wstrb;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_t bresp;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        axil_resp_t rresp;
        logic       rvalid;
    } axil_rsp_t;

endpackage

`default_nettype wire

// File: hdl/ram_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scratch RAM definitions
// byte lane layout of a word and the read/write collision mode
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ram_pkg;

    localparam int RAM_BYTE_W   = 8;
    localparam int RAM_BYTE_NUM = 4;

    typedef logic [RAM_BYTE_NUM*RAM_BYTE_W-1:0] ram_word_t;
    typedef logic [RAM_BYTE_NUM-1:0]            ram_be_t;

    // read port result when reading the word written in the same cycle
    typedef enum logic {
        RAM_NO_CHANGE,   // old contents
        RAM_WRITE_FIRST  // freshly written lanes
    } ram_mode_e;

endpackage

`default_nettype wire

// File: hdl/ram_sdp.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// simple-dual-port RAM
// byte-writable write port, registered read port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module ram_sdp
    import ram_pkg::*;
#(
    parameter int        MEM_DEPTH = 64,
    parameter ram_mode_e MEM_MODE  = RAM_NO_CHANGE
) (
    input  logic                         clk_i,
    input  ram_be_t                      wr_be_i,
    input  logic [$clog2(MEM_DEPTH)-1:0] wr_idx_i,
    input  ram_word_t                    wr_data_i,
    input  logic                         rd_en_i,
    input  logic [$clog2(MEM_DEPTH)-1:0] rd_idx_i,
    output ram_word_t                    rd_data_o
);

    ram_word_t mem [MEM_DEPTH];
    logic      collide;

    assign collide = (rd_idx_i == wr_idx_i);

    // per-lane write
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RAM_BYTE_NUM; i++) begin
            if (wr_be_i[i]) begin
                mem[wr_idx_i][i*RAM_BYTE_W +: RAM_BYTE_W] <= wr_data_i[i*RAM_BYTE_W +: RAM_BYTE_W];
            end
        end
    end

    // output register only loads on a read
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            for (int i = 0; i < RAM_BYTE_NUM; i++) begin
                if (MEM_MODE == RAM_WRITE_FIRST && collide && wr_be_i[i]) begin
                    rd_data_o[i*RAM_BYTE_W +: RAM_BYTE_W] <=
                        wr_data_i[i*RAM_BYTE_W +: RAM_BYTE_W]; // bypass
                end else begin
                    rd_data_o[i*RAM_BYTE_W +: RAM_BYTE_W] <=
                        mem[rd_idx_i][i*RAM_BYTE_W +: RAM_BYTE_W];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/axil_ram.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite RAM slave
// one write and one read in flight with OKAY responses
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module axil_ram
    import axil_pkg::*;
    import ram_pkg::*;
#(
    parameter int        MEM_DEPTH = 64,
    parameter ram_mode_e MEM_MODE  = RAM_NO_CHANGE
) (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  axil_req_t s_req_i,
    output axil_rsp_t s_rsp_o
);

    localparam int IDX_W    = $clog2(MEM_DEPTH);
    localparam int ADDR_LSB = $clog2(RAM_BYTE_NUM);  // word index starts here

    logic             wr_req;
    logic             wr_hs;
    logic             ar_hs;
    logic             wr_rdy_q;
    logic             bvalid_q;
    logic             ar_rdy_q;
    logic             rvalid_q;
    logic [IDX_W-1:0] wr_idx_q;
    logic [IDX_W-1:0] rd_idx_q;
    ram_be_t          wr_be;
    ram_word_t        rd_data;

    assign wr_req = s_req_i.awvalid & s_req_i.wvalid;
    assign wr_hs  = wr_req & wr_rdy_q;
    assign ar_hs  = s_req_i.arvalid & ar_rdy_q;
    assign wr_be  = wr_hs ? s_req_i.wstrb : '0;

    // write side accepts aw and w together
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_rdy_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            wr_rdy_q <= wr_req & ~wr_rdy_q & ~bvalid_q;
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (s_req_i.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_req & ~wr_rdy_q) begin
            wr_idx_q <= s_req_i.awaddr[ADDR_LSB +: IDX_W];
        end
    end

    // read side
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            ar_rdy_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            ar_rdy_q <= s_req_i.arvalid & ~ar_rdy_q & ~rvalid_q;
            if (ar_hs) begin
                rvalid_q <= 1'b1;
            end else if (s_req_i.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_req_i.arvalid & ~ar_rdy_q) begin
            rd_idx_q <= s_req_i.araddr[ADDR_LSB +: IDX_W];
        end
    end

    always_comb begin
        s_rsp_o.awready = wr_rdy_q;
        s_rsp_o.wready  = wr_rdy_q;
        s_rsp_o.bresp   = AXIL_OKAY;
        s_rsp_o.bvalid  = bvalid_q;
        s_rsp_o.arready = ar_rdy_q;
        s_rsp_o.rdata   = rd_data;  // held by the RAM output register
        s_rsp_o.rresp   = AXIL_OKAY;
        s_rsp_o.rvalid  = rvalid_q;
    end

    ram_sdp #(
        .MEM_DEPTH(MEM_DEPTH),
        .MEM_MODE (MEM_MODE)
    ) ram_sdp_inst (
        .clk_i    (clk_i),
        .wr_be_i  (wr_be),
        .wr_idx_i (wr_idx_q),
        .wr_data_i(s_req_i.wdata),
        .rd_en_i  (ar_hs),
        .rd_idx_i (rd_idx_q),
        .rd_data_o(rd_data)
    );

    // the one-cycle ready pulse always meets both valids
    a_wr_rdy_pulse: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wr_rdy_q |-> wr_req);

    // b response held under back-pressure
    a_bvalid_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (bvalid_q && !s_req_i.bready) |=> bvalid_q);

endmodule

`default_nettype wire

// File: hdl/axil_arbiter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-master AXI4-Lite arbiter
// round-robin grants on separate write and read paths
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module axil_arbiter
    import axil_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  axil_req_t m0_req_i,
    output axil_rsp_t m0_rsp_o,
    input  axil_req_t m1_req_i,
    output axil_rsp_t m1_rsp_o,
    output axil_req_t s_req_o,
    input  axil_rsp_t s_rsp_i
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_M0,
        ARB_M1
    } arb_state_e;

    arb_state_e wr_state;
    arb_state_e wr_next;
    arb_state_e rd_state;
    arb_state_e rd_next;
    logic       wr_last_m1;
    logic       rd_last_m1;
    logic       wr_req0;
    logic       wr_req1;
    logic       wr_done;
    logic       rd_done;
    axil_req_t  wr_src;
    axil_req_t  rd_src;

    // grant held until done with a round-robin pick from idle
    function automatic arb_state_e arb_next(arb_state_e cur, logic req0, logic req1,
                                            logic last_m1, logic done);
        arb_state_e nxt;
        nxt = cur;
        if (cur == ARB_IDLE) begin
            if (req0 && req1) begin
                nxt = last_m1 ? ARB_M0 : ARB_M1;
            end else if (req0) begin
                nxt = ARB_M0;
            end else if (req1) begin
                nxt = ARB_M1;
            end
        end else if (done) begin
            nxt = ARB_IDLE;
        end
        return nxt;
    endfunction

    // slave response fields go only to the path owner
    function automatic axil_rsp_t route_rsp(axil_rsp_t rsp, logic wr_own, logic rd_own);
        axil_rsp_t r;
        r = '0;
        if (wr_own) begin
            r.awready = rsp.awready;
            r.wready  = rsp.wready;
            r.bresp   = rsp.bresp;
            r.bvalid  = rsp.bvalid;
        end
        if (rd_own) begin
            r.arready = rsp.arready;
            r.rdata   = rsp.rdata;
            r.rresp   = rsp.rresp;
            r.rvalid  = rsp.rvalid;
        end
        return r;
    endfunction

    assign wr_req0 = m0_req_i.awvalid | m0_req_i.wvalid;
    assign wr_req1 = m1_req_i.awvalid | m1_req_i.wvalid;
    assign wr_done = s_rsp_i.bvalid & s_req_o.bready;
    assign rd_done = s_rsp_i.rvalid & s_req_o.rready;

    assign wr_next = arb_next(wr_state, wr_req0, wr_req1, wr_last_m1, wr_done);
    assign rd_next = arb_next(rd_state, m0_req_i.arvalid, m1_req_i.arvalid,
                              rd_last_m1, rd_done);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_state   <= ARB_IDLE;
            rd_state   <= ARB_IDLE;
            wr_last_m1 <= 1'b1;  // m0 first
            rd_last_m1 <= 1'b1;
        end else begin
            wr_state <= wr_next;
            rd_state <= rd_next;
            if (wr_state == ARB_IDLE && wr_next != ARB_IDLE) wr_last_m1 <= (wr_next == ARB_M1);
            if (rd_state == ARB_IDLE && rd_next != ARB_IDLE) rd_last_m1 <= (rd_next == ARB_M1);
        end
    end

    assign wr_src = (wr_state == ARB_M1) ? m1_req_i : m0_req_i;
    assign rd_src = (rd_state == ARB_M1) ? m1_req_i : m0_req_i;

    always_comb begin
        s_req_o.awaddr  = wr_src.awaddr;
        s_req_o.awvalid = wr_src.awvalid & (wr_state != ARB_IDLE);
        s_req_o.wdata   = wr_src.wdata;
        s_req_o.wstrb   = wr_src.wstrb;
        s_req_o.wvalid  = wr_src.wvalid & (wr_state != ARB_IDLE);
        s_req_o.bready  = wr_src.bready & (wr_state != ARB_IDLE);
        s_req_o.araddr  = rd_src.araddr;
        s_req_o.arvalid = rd_src.arvalid & (rd_state != ARB_IDLE);
        s_req_o.rready  = rd_src.rready & (rd_state != ARB_IDLE);
    end

    assign m0_rsp_o = route_rsp(s_rsp_i, wr_state == ARB_M0, rd_state == ARB_M0);
    assign m1_rsp_o = route_rsp(s_rsp_i, wr_state == ARB_M1, rd_state == ARB_M1);

    // a granted path only moves on its response handshake
    a_wr_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (wr_state != ARB_IDLE && !wr_done) |=> wr_state == $past(wr_state));
    a_rd_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (rd_state != ARB_IDLE && !rd_done) |=> rd_state == $past(rd_state));

    // no grant to a master that was not asking
    a_wr_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wr_state == ARB_IDLE |=> (wr_state != ARB_M0 || $past(wr_req0))
                              && (wr_state != ARB_M1 || $past(wr_req1)));
    a_rd_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        rd_state == ARB_IDLE |=> (rd_state != ARB_M0 || $past(m0_req_i.arvalid))
                              && (rd_state != ARB_M1 || $past(m1_req_i.arvalid)));

endmodule

`default_nettype wire

// File: hdl/ram_subsys_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared scratch RAM subsystem
// two AXI4-Lite masters arbitrated onto one RAM slave
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module ram_subsys_top
    import axil_pkg::*;
    import ram_pkg::*;
#(
    parameter int        MEM_DEPTH = 64,
    parameter ram_mode_e MEM_MODE  = RAM_NO_CHANGE
) (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  axil_req_t m0_req_i,
    output axil_rsp_t m0_rsp_o,
    input  axil_req_t m1_req_i,
    output axil_rsp_t m1_rsp_o
);

    axil_req_t s_req;  // arbiter to slave
    axil_rsp_t s_rsp;

    axil_arbiter axil_arbiter_inst (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .m0_req_i(m0_req_i),
        .m0_rsp_o(m0_rsp_o),
        .m1_req_i(m1_req_i),
        .m1_rsp_o(m1_rsp_o),
        .s_req_o (s_req),
        .s_rsp_i (s_rsp)
    );

    axil_ram #(
        .MEM_DEPTH(MEM_DEPTH),
        .MEM_MODE (MEM_MODE)
    ) axil_ram_inst (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .s_req_i(s_req),
        .s_rsp_o(s_rsp)
    );

endmodule

`default_nettype wire

// File: sim/tb_checker.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench checker for the scratch RAM subsystem
// reference memory, response routing, hold and round-robin rules
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module tb_checker
    import axil_pkg::*;
#(
    parameter int MEM_DEPTH = 64
) (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  axil_req_t m0_req_i,
    input  axil_rsp_t m0_rsp_i,
    input  axil_req_t m1_req_i,
    input  axil_rsp_t m1_rsp_i,
    output int        err_cnt_o,
    output int        resp_cnt_o
);

    localparam int IDX_W = $clog2(MEM_DEPTH);

    axil_req_t  req [2];
    axil_rsp_t  rsp [2];
    axil_rsp_t  rsp_prev [2];
    axil_data_t ref_mem [MEM_DEPTH];
    axil_addr_t rd_addr [2];
    logic       wr_pend [2];
    logic       rd_pend [2];
    logic       b_stall [2];
    logic       r_stall [2];
    logic       started;   // first request seen
    int         wr_owed;   // master next in line or -1
    int         rd_owed;

    assign req[0] = m0_req_i;
    assign req[1] = m1_req_i;
    assign rsp[0] = m0_rsp_i;
    assign rsp[1] = m1_rsp_i;

    function automatic axil_data_t merge_word(axil_data_t old, axil_data_t data,
                                              axil_strb_t strb);
        axil_data_t w;
        w = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) w[8*b +: 8] = data[8*b +: 8];
        end
        return w;
    endfunction

    // word index is address bits 2 and up
    function automatic axil_data_t ref_read(axil_addr_t addr);
        return ref_mem[addr[2 +: IDX_W]];
    endfunction

    task automatic flag_error(input string msg);
        err_cnt_o = err_cnt_o + 1;
        $display("ERROR @ %0t: %s", $time, msg);
    endtask

    always @(posedge clk_i) begin
        if (!rstn_i) begin
            err_cnt_o  = 0;
            resp_cnt_o = 0;
            started    = 1'b0;
            wr_owed    = -1;
            rd_owed    = -1;
            for (int m = 0; m < 2; m++) begin
                wr_pend[m] = 1'b0;
                rd_pend[m] = 1'b0;
                b_stall[m] = 1'b0;
                r_stall[m] = 1'b0;
            end
        end else begin
            for (int m = 0; m < 2; m++) begin
                if (!started && (rsp[m].awready || rsp[m].wready || rsp[m].arready
                                 || rsp[m].bvalid || rsp[m].rvalid))
                    flag_error($sformatf("m%0d response active before any request", m));
                if (b_stall[m] && (!rsp[m].bvalid || rsp[m].bresp != rsp_prev[m].bresp))
                    flag_error($sformatf("m%0d B response changed while stalled", m));
                if (r_stall[m] && (!rsp[m].rvalid || rsp[m].rdata !== rsp_prev[m].rdata
                                   || rsp[m].rresp != rsp_prev[m].rresp))
                    flag_error($sformatf("m%0d R response changed while stalled", m));
                if (rsp[m].bvalid && !wr_pend[m])
                    flag_error($sformatf("bvalid on m%0d with no write outstanding", m));
                if (rsp[m].rvalid && !rd_pend[m])
                    flag_error($sformatf("rvalid on m%0d with no read outstanding", m));
                if (rsp[m].bvalid && req[m].bready) begin
                    resp_cnt_o = resp_cnt_o + 1;
                    wr_pend[m] = 1'b0;
                    if (rsp[m].bresp != AXIL_OKAY) flag_error($sformatf("m%0d bresp not OKAY", m));
                    if (wr_owed >= 0 && wr_owed != m)
                        flag_error($sformatf("write served m%0d while m%0d waited", m, wr_owed));
                    wr_owed = (req[1-m].awvalid || req[1-m].wvalid) ? 1 - m : -1;
                end
                if (rsp[m].rvalid && req[m].rready) begin
                    resp_cnt_o = resp_cnt_o + 1;
                    rd_pend[m] = 1'b0;
                    if (rsp[m].rdata !== ref_read(rd_addr[m]))
                        flag_error($sformatf("m%0d read %h returned %h, expected %h", m,
                                             rd_addr[m], rsp[m].rdata, ref_read(rd_addr[m])));
                    if (rsp[m].rresp != AXIL_OKAY) flag_error($sformatf("m%0d rresp not OKAY", m));
                    if (rd_owed >= 0 && rd_owed != m)
                        flag_error($sformatf("read served m%0d while m%0d waited", m, rd_owed));
                    rd_owed = req[1-m].arvalid ? 1 - m : -1;
                end
                if (req[m].arvalid && rsp[m].arready) begin
                    rd_pend[m] = 1'b1;
                    rd_addr[m] = req[m].araddr;
                end
                b_stall[m]  = rsp[m].bvalid & ~req[m].bready;
                r_stall[m]  = rsp[m].rvalid & ~req[m].rready;
                rsp_prev[m] = rsp[m];
            end
            // writes land after the reads of the same edge
            for (int m = 0; m < 2; m++) begin
                if (req[m].awvalid && rsp[m].awready && req[m].wvalid && rsp[m].wready) begin
                    ref_mem[req[m].awaddr[2 +: IDX_W]] =
                        merge_word(ref_mem[req[m].awaddr[2 +: IDX_W]], req[m].wdata, req[m].wstrb);
                    wr_pend[m] = 1'b1;
                end
            end
            started = started | req[0].awvalid | req[0].wvalid | req[0].arvalid
                              | req[1].awvalid | req[1].wvalid | req[1].arvalid;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench top for the scratch RAM subsystem
// two LFSR-driven AXI4-Lite masters, reset and watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/100ps

module tb_top
    import axil_pkg::*;
();

    localparam int MEM_DEPTH   = 64;
    localparam int HALF        = MEM_DEPTH / 2;  // words per master
    localparam int HW          = $clog2(HALF);
    localparam int N_RAND      = 96;
    localparam int N_TOTAL     = 2 * (2 * HALF + N_RAND);
    localparam int CLK_NS      = 8;
    localparam int WATCHDOG_NS = N_TOTAL * 40 * CLK_NS;

    logic        clk;
    logic        rstn;
    axil_req_t   req_q [2];
    axil_rsp_t   m0_rsp;
    axil_rsp_t   m1_rsp;
    axil_rsp_t   rsp_w [2];
    logic [31:0] lfsr_q [2];
    int          err_cnt;
    int          resp_cnt;

    assign rsp_w[0] = m0_rsp;
    assign rsp_w[1] = m1_rsp;

    always #(CLK_NS / 2) clk = ~clk;

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic draw_bits(input int m, input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[m][0]};
            lfsr_q[m] = lfsr_next(lfsr_q[m]);
        end
    endtask

    // one access from master m up to its response
    task automatic access(input int m, input logic wr, input int idx, input axil_data_t data,
                          input axil_strb_t strb);
        logic [31:0] r;
        logic        done;
        @(negedge clk);
        if (wr) begin
            req_q[m].awaddr  = axil_addr_t'(idx * 4);
            req_q[m].wdata   = data;
            req_q[m].wstrb   = strb;
            req_q[m].awvalid = 1'b1;
            req_q[m].wvalid  = 1'b1;
            @(negedge clk);
            while (!rsp_w[m].awready) @(negedge clk);
        end else begin
            req_q[m].araddr  = axil_addr_t'(idx * 4);
            req_q[m].arvalid = 1'b1;
            @(negedge clk);
            while (!rsp_w[m].arready) @(negedge clk);
        end
        @(negedge clk);  // accepted on the edge just passed
        req_q[m].awvalid = 1'b0;
        req_q[m].wvalid  = 1'b0;
        req_q[m].arvalid = 1'b0;
        done = 1'b0;
        while (!done) begin
            draw_bits(m, 2, r);  // ready low one cycle in four
            if (wr) req_q[m].bready = (r[1:0] != 2'b00);
            else req_q[m].rready = (r[1:0] != 2'b00);
            if (wr ? (rsp_w[m].bvalid && req_q[m].bready) : (rsp_w[m].rvalid && req_q[m].rready))
                done = 1'b1;
            else
                @(negedge clk);
        end
        @(negedge clk);
        req_q[m].bready = 1'b0;
        req_q[m].rready = 1'b0;
    endtask

    task automatic run_master(input int m);
        logic [31:0] r;
        logic [31:0] d;
        int          base;
        base = m * HALF;
        if (m == 1) draw_bits(m, 7, r);  // keeps the two streams apart
        for (int i = 0; i < HALF; i++) begin
            draw_bits(m, 32, d);
            access(m, 1'b1, base + i, d, 4'hf);
            access(m, 1'b0, base + i, '0, '0);
        end
        for (int i = 0; i < N_RAND; i++) begin
            draw_bits(m, 5 + HW, r);  // op, word, strobes
            draw_bits(m, 32, d);
            access(m, r[4 + HW], base + int'((r >> 4) % HALF), d, r[3:0]);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        req_q[0]  = '0;
        req_q[1]  = '0;
        lfsr_q[0] = 32'hf089a50f;
        lfsr_q[1] = 32'hf089a50f;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        repeat (4) @(negedge clk);  // idle ports after reset
        fork
            run_master(0);
            run_master(1);
        join
        repeat (4) @(negedge clk);
        if (resp_cnt != N_TOTAL) $display("response count does not match the accesses issued");
        $display("responses: %0d of %0d, errors: %0d", resp_cnt, N_TOTAL, err_cnt);
        if (err_cnt == 0 && resp_cnt == N_TOTAL) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with accesses still open", WATCHDOG_NS);
        $display("Simulation FAILED");
        $finish;
    end

    ram_subsys_top #(
        .MEM_DEPTH(MEM_DEPTH)
    ) ram_subsys_top_inst (
        .clk_i   (clk),
        .rstn_i  (rstn),
        .m0_req_i(req_q[0]),
        .m0_rsp_o(m0_rsp),
        .m1_req_i(req_q[1]),
        .m1_rsp_o(m1_rsp)
    );

    tb_checker #(
        .MEM_DEPTH(MEM_DEPTH)
    ) tb_checker_inst (
        .clk_i     (clk),
        .rstn_i    (rstn),
        .m0_req_i  (req_q[0]),
        .m0_rsp_i  (m0_rsp),
        .m1_req_i  (req_q[1]),
        .m1_rsp_i  (m1_rsp),
        .err_cnt_o (err_cnt),
        .resp_cnt_o(resp_cnt)
    );

endmodule

`default_nettype wire

// File: sim.f
hdl/axil_pkg.sv
hdl/ram_pkg.sv
hdl/ram_sdp.sv
hdl/axil_ram.sv
hdl/axil_arbiter.sv
hdl/ram_subsys_top.sv
sim/tb_checker.sv
sim/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build the scratch RAM testbench with Verilator, run it, check the log

rm -f sim.log \
    && verilator --binary --timing --assert --top-module tb_top -f sim.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    && grep -q "Simulation PASSED" sim.log \
    && echo "run_sim: passed" \
    || { echo "run_sim: failed, see sim.log"; exit 1; }
